//--- alu_exec_element.sv
`timescale 1ns/1ps
`include "exec_core_consts.svh"

module alu_exec_element (
	input logic clk,
	input logic reset,
	input logic start,
	output logic completed,
	input exec_pkg::alu_op_t inst_num,
	input exec_pkg::imm16_t const16,
	input exec_pkg::word_t const16_x,
	input exec_pkg::shamt_t shift5,
	input exec_pkg::word_t rs,
	input exec_pkg::word_t rt,
	output exec_pkg::word_t out
);

	import exec_pkg::*;

	localparam int w = `EXEC_DATA_W;

	word_t stage [6];
	logic shift_fill;
	word_t quick_res;
	word_t div_a;
	word_t div_b;
	word_t div_b_sel;
	word_t div_c;
	logic div_enabled;
	logic div_completed;
	word_t mul_b;
	word_t mul_lo;
	logic mul_wait;
	logic busy;

	divider u_divider (
		.clk(clk),
		.reset(reset),
		.enabled(div_enabled),
		.a(div_a),
		.b(div_b),
		.c(div_c),
		.completed(div_completed)
	);

	assign div_b_sel = (inst_num == op_divi) ? const16_x : rt;
	assign mul_b = (inst_num == op_multi) ? const16_x : rt;
	assign busy = mul_wait || div_enabled;

	// Barrel shifter with one stage per bit of shift5
	assign stage[0] = rs;
	assign shift_fill = (inst_num == op_sra) && rs[w-1];  // Sign fill for SRA only

	for (genvar i = 0; i < 5; i++) begin : g_shift
		localparam int amt = 2 ** i;

		always_comb begin
			if (!shift5[i]) begin
				stage[i+1] = stage[i];
			end else if (inst_num == op_sll) begin
				stage[i+1] = {stage[i][w-1-amt:0], {amt{1'b0}}};
			end else begin
				stage[i+1] = {{amt{shift_fill}}, stage[i][w-1:amt]};
			end
		end
	end

	// Results that finish in the start cycle
	always_comb begin
		case (inst_num)
			op_add: begin
				quick_res = rs + rt;
			end
			op_addi: begin
				quick_res = rs + const16_x;
			end
			op_sub: begin
				quick_res = rs - rt;
			end
			op_lui: begin
				quick_res = {const16, 16'h0000};
			end
			op_sll, op_sra, op_srl: begin
				quick_res = stage[5];
			end
			op_and: begin
				quick_res = rs & rt;
			end
			op_andi: begin
				quick_res = {16'h0000, rs[15:0] & const16};  // Zero-extended
			end
			op_or: begin
				quick_res = rs | rt;
			end
			op_ori: begin
				quick_res = {rs[w-1:16], rs[15:0] | const16};
			end
			op_xor: begin
				quick_res = rs ^ rt;
			end
			op_xori: begin
				quick_res = {rs[w-1:16], rs[15:0] ^ const16};
			end
			op_nor: begin
				quick_res = ~(rs | rt);
			end
			default: begin
				quick_res = '0;  // Unknown op reports zero
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			completed <= 1'b0;
			mul_wait <= 1'b0;
			div_enabled <= 1'b0;
		end else begin
			completed <= 1'b0;
			if (start) begin
				case (inst_num)
					op_mult, op_multi: begin
						mul_wait <= 1'b1;
					end
					op_div, op_divi: begin
						div_enabled <= 1'b1;
					end
					default: begin
						completed <= 1'b1;
					end
				endcase
			end else if (mul_wait) begin
				mul_wait <= 1'b0;
				completed <= 1'b1;
			end else if (div_enabled && div_completed) begin
				div_enabled <= 1'b0;  // Rearms the divider edge detect
				completed <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			div_a <= rs;
			div_b <= div_b_sel;
			mul_lo <= $signed(rs) * $signed(mul_b);  // Low word of signed product
			out <= quick_res;
		end else if (mul_wait) begin
			out <= mul_lo;
		end else if (div_enabled && div_completed) begin
			out <= div_c;
		end
	end

	a_completed_pulse: assert property (@(posedge clk) disable iff (reset)
		completed |=> !completed);

	a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
		start |-> !busy);

endmodule

//--- divider.sv
`timescale 1ns/1ps
`include "exec_core_consts.svh"

module divider (
	input logic clk,
	input logic reset,
	input logic enabled,
	input exec_pkg::word_t a,
	input exec_pkg::word_t b,
	output exec_pkg::word_t c,
	output logic completed
);

	import exec_pkg::*;

	localparam int w = `EXEC_DATA_W;
	localparam int step_w = $clog2(`EXEC_DIV_STEPS + 1);

	logic enabled_q;
	logic busy;
	logic go;
	logic fits;
	logic [step_w-1:0] step_cnt;
	word_t rem;
	word_t quot;
	word_t rem_src;
	word_t quot_src;
	logic [w:0] trial;
	logic [w:0] diff;

	// Start only on a fresh rising edge of enabled
	assign go = enabled && !enabled_q && !busy;

	// First step runs on the load edge straight from a
	assign rem_src = busy ? rem : '0;
	assign quot_src = busy ? quot : a;
	assign trial = {rem_src, quot_src[w-1]};
	assign diff = trial - {1'b0, b};
	assign fits = trial >= {1'b0, b};  // Always true for b == 0

	always_ff @(posedge clk) begin
		if (reset) begin
			enabled_q <= 1'b0;
			busy <= 1'b0;
			step_cnt <= '0;
			completed <= 1'b0;
		end else begin
			enabled_q <= enabled;
			completed <= 1'b0;
			if (go) begin
				busy <= 1'b1;
				step_cnt <= step_w'(1);
			end else if (busy) begin
				step_cnt <= step_cnt + 1'b1;
				if (step_cnt == step_w'(`EXEC_DIV_STEPS - 1)) begin  // Last quotient bit
					busy <= 1'b0;
					completed <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (go || busy) begin
			quot <= {quot_src[w-2:0], fits};
			rem <= fits ? diff[w-1:0] : trial[w-1:0];
		end
	end

	assign c = quot;

	a_done_while_enabled: assert property (@(posedge clk) disable iff (reset)
		completed |-> enabled);

endmodule

//--- exec_control.sv
`timescale 1ns/1ps

module exec_control (
	input logic clk,
	input logic reset,
	input logic inst_valid,
	output logic inst_ready,
	input exec_pkg::word_t inst,
	output exec_pkg::word_t inst_word,
	input exec_pkg::reg_idx_t rd,
	output logic alu_start,
	input logic alu_completed,
	input exec_pkg::word_t alu_out,
	output logic res_valid,
	input logic res_ready,
	output exec_pkg::reg_idx_t res_rd,
	output exec_pkg::word_t res_data,
	output logic wr_en,
	output exec_pkg::reg_idx_t wr_idx,
	output exec_pkg::word_t wr_data
);

	typedef enum logic [1:0] {
		st_idle,
		st_exec,
		st_hold
	} state_t;

	state_t state;

	assign inst_ready = (state == st_idle);
	assign res_valid = (state == st_hold);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			alu_start <= 1'b0;
		end else begin
			alu_start <= 1'b0;
			case (state)
				st_idle: begin
					if (inst_valid) begin
						state <= st_exec;
						alu_start <= 1'b1;  // ALU sees decoded word next cycle
					end
				end
				st_exec: begin
					if (alu_completed) begin
						state <= st_hold;
					end
				end
				default: begin
					if (res_ready) begin
						state <= st_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid && inst_ready) begin
			inst_word <= inst;
		end
		if ((state == st_exec) && alu_completed) begin
			res_data <= alu_out;
		end
	end

	// Writeback commits at the result handshake
	assign res_rd = rd;
	assign wr_en = res_valid && res_ready;
	assign wr_idx = rd;
	assign wr_data = res_data;

	a_res_stable: assert property (@(posedge clk) disable iff (reset)
		(res_valid && !res_ready) |=> (res_valid && $stable(res_rd) && $stable(res_data)));

endmodule

//--- exec_core.f
+incdir+.
exec_pkg.sv
inst_decoder.sv
reg_file.sv
divider.sv
alu_exec_element.sv
exec_control.sv
exec_core.sv
tb_exec_core.sv

//--- exec_core.sv
`timescale 1ns/1ps

module exec_core (
	input logic clk,
	input logic reset,
	input logic inst_valid,
	output logic inst_ready,
	input exec_pkg::word_t inst,
	output logic res_valid,
	input logic res_ready,
	output exec_pkg::reg_idx_t res_rd,
	output exec_pkg::word_t res_data
);

	import exec_pkg::*;

	word_t inst_word;
	alu_op_t op;
	reg_idx_t rd_idx;
	reg_idx_t rs_idx;
	reg_idx_t rt_idx;
	shamt_t shift5;
	imm16_t const16;
	word_t const16_x;
	word_t rs_data;
	word_t rt_data;
	logic alu_start;
	logic alu_completed;
	word_t alu_out;
	logic wr_en;
	reg_idx_t wr_idx;
	word_t wr_data;

	inst_decoder u_decoder (
		.inst(inst_word),
		.op(op),
		.rd(rd_idx),
		.rs(rs_idx),
		.rt(rt_idx),
		.shift5(shift5),
		.const16(const16),
		.const16_x(const16_x)
	);

	reg_file u_reg_file (
		.clk(clk),
		.reset(reset),
		.rd_idx_a(rs_idx),
		.rd_idx_b(rt_idx),
		.rd_data_a(rs_data),
		.rd_data_b(rt_data),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_data(wr_data)
	);

	exec_control u_control (
		.clk(clk),
		.reset(reset),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.inst(inst),
		.inst_word(inst_word),
		.rd(rd_idx),
		.alu_start(alu_start),
		.alu_completed(alu_completed),
		.alu_out(alu_out),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res_rd(res_rd),
		.res_data(res_data),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_data(wr_data)
	);

	alu_exec_element u_alu (
		.clk(clk),
		.reset(reset),
		.start(alu_start),
		.completed(alu_completed),
		.inst_num(op),
		.const16(const16),
		.const16_x(const16_x),
		.shift5(shift5),
		.rs(rs_data),
		.rt(rt_data),
		.out(alu_out)
	);

endmodule

//--- exec_core_consts.svh
`ifndef EXEC_CORE_CONSTS_SVH
`define EXEC_CORE_CONSTS_SVH

// Data path and instruction word width
`define EXEC_DATA_W 32

`define EXEC_REG_COUNT 32

`define EXEC_REG_IDX_W 5

// One quotient bit per divider step
`define EXEC_DIV_STEPS 32

`endif

//--- exec_pkg.sv
`include "exec_core_consts.svh"

package exec_pkg;

	typedef logic [`EXEC_DATA_W-1:0] word_t;
	typedef logic [`EXEC_REG_IDX_W-1:0] reg_idx_t;
	typedef logic [4:0] shamt_t;
	typedef logic [15:0] imm16_t;

	typedef enum logic [5:0] {
		op_add   = 6'd8,
		op_addi  = 6'd9,
		op_sub   = 6'd10,
		op_lui   = 6'd11,
		op_div   = 6'd12,
		op_mult  = 6'd13,
		op_divi  = 6'd14,
		op_multi = 6'd15,
		op_sll   = 6'd16,
		op_sra   = 6'd17,
		op_srl   = 6'd18,
		op_and   = 6'd20,
		op_andi  = 6'd21,
		op_or    = 6'd22,
		op_ori   = 6'd23,
		op_xor   = 6'd24,
		op_xori  = 6'd25,
		op_nor   = 6'd26,
		op_unk   = 6'd63  // Any opcode outside the set
	} alu_op_t;

endpackage

//--- inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
	input exec_pkg::word_t inst,
	output exec_pkg::alu_op_t op,
	output exec_pkg::reg_idx_t rd,
	output exec_pkg::reg_idx_t rs,
	output exec_pkg::reg_idx_t rt,
	output exec_pkg::shamt_t shift5,
	output exec_pkg::imm16_t const16,
	output exec_pkg::word_t const16_x
);

	import exec_pkg::*;

	logic [5:0] op_raw;

	assign op_raw = inst[31:26];

	// Only defined encodings pass through
	always_comb begin
		case (op_raw) inside
			[6'd8:6'd18], [6'd20:6'd26]: begin
				op = alu_op_t'(op_raw);
			end
			default: begin
				op = op_unk;
			end
		endcase
	end

	assign rd = inst[25:21];
	assign rs = inst[20:16];
	assign rt = inst[15:11];
	assign shift5 = inst[10:6];

	// Immediate overlaps rt and shift5
	assign const16 = inst[15:0];
	assign const16_x = {{16{inst[15]}}, inst[15:0]};

endmodule

//--- reg_file.sv
`timescale 1ns/1ps
`include "exec_core_consts.svh"

module reg_file (
	input logic clk,
	input logic reset,
	input exec_pkg::reg_idx_t rd_idx_a,
	input exec_pkg::reg_idx_t rd_idx_b,
	output exec_pkg::word_t rd_data_a,
	output exec_pkg::word_t rd_data_b,
	input logic wr_en,
	input exec_pkg::reg_idx_t wr_idx,
	input exec_pkg::word_t wr_data
);

	import exec_pkg::*;

	word_t regs [`EXEC_REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `EXEC_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_idx != '0)) begin  // r0 is never written
			regs[wr_idx] <= wr_data;
		end
	end

	assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
	assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_exec_core \
	-f exec_core.f \
	-o sim_exec_core

./obj_dir/sim_exec_core | tee sim.log

if grep -q "TEST PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

//--- tb_alu_model.svh
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

function automatic logic [31:0] encode_reg(input logic [5:0] op, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sh);
	return {op, rd, rs, rt, sh, 6'b000000};
endfunction

function automatic logic [31:0] encode_imm(input logic [5:0] op, input logic [4:0] rd,
		input logic [4:0] rs, input logic [15:0] imm);
	return {op, rd, rs, imm};
endfunction

function automatic logic [4:0] dest_reg(input logic [31:0] word);
	return word[25:21];
endfunction

function automatic logic single_cycle_op(input logic [31:0] word);
	logic [5:0] op;
	op = word[31:26];
	return !((op == op_mult) || (op == op_multi) || (op == op_div) || (op == op_divi));
endfunction

// Expected ALU result from the source values and the encoding fields
function automatic logic [31:0] expected_result(input logic [31:0] word,
		input logic [31:0] rs_val, input logic [31:0] rt_val);
	logic [15:0] imm;
	logic [31:0] imm_x;
	logic [4:0] sh;
	logic signed [63:0] prod;
	logic [31:0] r;
	imm = word[15:0];
	imm_x = {{16{imm[15]}}, imm};
	sh = word[10:6];
	prod = '0;
	case (word[31:26])
		op_add: r = rs_val + rt_val;
		op_addi: r = rs_val + imm_x;
		op_sub: r = rs_val - rt_val;
		op_lui: r = {imm, 16'h0000};
		op_div: r = (rt_val == 32'd0) ? 32'hffff_ffff : rs_val / rt_val;
		op_divi: r = (imm_x == 32'd0) ? 32'hffff_ffff : rs_val / imm_x;
		op_mult: begin
			prod = $signed(rs_val) * $signed(rt_val);
			r = prod[31:0];
		end
		op_multi: begin
			prod = $signed(rs_val) * $signed(imm_x);
			r = prod[31:0];
		end
		op_sll: r = rs_val << sh;
		op_sra: r = $signed(rs_val) >>> sh;  // Sign fill
		op_srl: r = rs_val >> sh;
		op_and: r = rs_val & rt_val;
		op_andi: r = rs_val & {16'h0000, imm};
		op_or: r = rs_val | rt_val;
		op_ori: r = rs_val | {16'h0000, imm};
		op_xor: r = rs_val ^ rt_val;
		op_xori: r = rs_val ^ {16'h0000, imm};
		op_nor: r = ~(rs_val | rt_val);
		default: r = 32'd0;
	endcase
	return r;
endfunction

`endif

//--- tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core;

	import exec_pkg::*;

	`include "tb_alu_model.svh"

	localparam int total_insts = 180;
	localparam int watchdog_cycles = 16 + total_insts * 60 + 200;

	logic clk;
	logic reset;
	logic inst_valid;
	logic inst_ready;
	logic [31:0] inst;
	logic res_valid;
	logic res_ready;
	logic [4:0] res_rd;
	logic [31:0] res_data;

	integer seed = 32'hfb4c_4ab8;
	logic [31:0] shadow [32];
	logic [31:0] exp_data;
	logic [4:0] exp_rd;
	logic exp_single;
	logic bp_mode;
	logic [5:0] op_pool [$];
	string cur_test;
	int err_count;
	int issued;
	int hs_count;
	int n_tests;
	int test_err0;
	int test_n0;

	exec_core uut (
		.clk(clk),
		.reset(reset),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.inst(inst),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res_rd(res_rd),
		.res_data(res_data)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		if (!reset && res_valid && res_ready) begin
			hs_count++;
		end
	end

	a_result_match: assert property (@(posedge clk) disable iff (reset)
		(res_valid && res_ready) |-> (res_data == exp_data && res_rd == exp_rd))
		else begin
			$display("error %s: expected rd %0d data %h, actual rd %0d data %h", cur_test,
				$sampled(exp_rd), $sampled(exp_data), $sampled(res_rd), $sampled(res_data));
			err_count++;
		end

	a_hold_stable: assert property (@(posedge clk) disable iff (reset)
		(res_valid && !res_ready) |=> (res_valid && $stable(res_rd) && $stable(res_data)))
		else begin
			$display("%s: result changed or dropped while res_ready was low", cur_test);
			err_count++;
		end

	a_ready_low: assert property (@(posedge clk) disable iff (reset)
		res_valid |-> !inst_ready)
		else begin
			$display("%s: inst_ready high while a result is pending", cur_test);
			err_count++;
		end

	a_no_repeat: assert property (@(posedge clk) disable iff (reset)
		(res_valid && res_ready) |=> !res_valid)
		else begin
			$display("%s: result offered again after it was retired", cur_test);
			err_count++;
		end

	// Single-cycle ops raise res_valid two cycles after accept
	a_single_latency: assert property (@(posedge clk) disable iff (reset)
		(res_valid && !$past(res_valid) && exp_single) |-> $past(inst_valid && inst_ready, 3))
		else begin
			$display("%s: single-cycle result did not appear two cycles after accept", cur_test);
			err_count++;
		end

	task automatic issue(input logic [31:0] word);
		logic done;
		exp_rd = dest_reg(word);
		exp_data = expected_result(word, shadow[word[20:16]], shadow[word[15:11]]);
		exp_single = single_cycle_op(word);
		inst = word;
		inst_valid = 1'b1;
		while (!inst_ready) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);  // Accept edge
		#1;
		inst_valid = 1'b0;
		done = 1'b0;
		while (!done) begin
			res_ready = bp_mode ? ({$random(seed)} % 3 == 0) : 1'b1;
			done = res_valid && res_ready;
			@(posedge clk);
			#1;
		end
		if (exp_rd != 5'd0) begin
			shadow[exp_rd] = exp_data;
		end
		issued++;
	endtask

	task automatic random_batch(input int count);
		logic [31:0] rnd;
		logic [5:0] op;
		for (int i = 0; i < count; i++) begin
			rnd = $random(seed);
			op = op_pool[{$random(seed)} % op_pool.size()];
			issue({op, rnd[25:0]});
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_err0 = err_count;
		test_n0 = issued;
	endtask

	task automatic finish_test();
		$display("%s: %0d instructions, %0d errors", cur_test, issued - test_n0,
			err_count - test_err0);
		n_tests++;
	endtask

	initial begin
		#(watchdog_cycles * 10);
		$display("timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		logic [31:0] rnd;
		logic [4:0] r;
		clk = 1'b0;
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		res_ready = 1'b0;
		bp_mode = 1'b0;
		exp_data = '0;
		exp_rd = '0;
		exp_single = 1'b0;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
		end
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		start_test("reset");
		assert (inst_ready && !res_valid)
			else begin
				$display("reset: inst_ready %b res_valid %b after reset", inst_ready, res_valid);
				err_count++;
			end
		issue(encode_reg(op_add, 5'd3, 5'd0, 5'd0, 5'd0));
		finish_test();

		start_test("load");
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			r = (rnd[4:0] == 5'd0) ? 5'd1 : rnd[4:0];
			issue(encode_imm(op_lui, r, 5'd0, rnd[31:16]));
			rnd = $random(seed);
			issue(encode_imm(op_ori, r, r, rnd[15:0]));
			issue(encode_reg(op_add, rnd[20:16], r, 5'd0, 5'd0));  // Read back
		end
		issue(encode_imm(op_lui, 5'd0, 5'd0, 16'hbeef));
		issue(encode_reg(op_add, 5'd7, 5'd0, 5'd0, 5'd0));  // r0 still zero
		finish_test();

		start_test("alu");
		op_pool = '{op_add, op_addi, op_sub, op_and, op_andi, op_or, op_ori, op_xor,
			op_xori, op_nor, 6'd0, 6'd19, 6'd27, 6'd63};
		random_batch(60);
		finish_test();

		start_test("muldiv");
		op_pool = '{op_mult, op_multi, op_div, op_divi};
		random_batch(24);
		issue(encode_reg(op_div, 5'd9, 5'd5, 5'd0, 5'd0));
		issue(encode_imm(op_divi, 5'd10, 5'd5, 16'h0000));
		finish_test();

		start_test("shift");
		issue(encode_imm(op_lui, 5'd30, 5'd0, 16'h8421));
		issue(encode_reg(op_sll, 5'd29, 5'd30, 5'd0, 5'd0));
		issue(encode_reg(op_sra, 5'd29, 5'd30, 5'd0, 5'd0));
		issue(encode_reg(op_srl, 5'd29, 5'd30, 5'd0, 5'd0));
		issue(encode_reg(op_sll, 5'd28, 5'd30, 5'd0, 5'd31));
		issue(encode_reg(op_sra, 5'd28, 5'd30, 5'd0, 5'd31));
		issue(encode_reg(op_srl, 5'd28, 5'd30, 5'd0, 5'd31));
		op_pool = '{op_sll, op_sra, op_srl};
		random_batch(30);
		finish_test();

		start_test("backpressure");
		bp_mode = 1'b1;
		op_pool = '{op_add, op_sub, op_mult, op_div, op_divi, op_sra, op_xori, op_lui};
		random_batch(30);
		bp_mode = 1'b0;
		finish_test();

		assert (hs_count == issued)
			else begin
				$display("%0d results retired for %0d instructions issued", hs_count, issued);
				err_count++;
			end
		$display("tests %0d, instructions %0d, retired %0d, errors %0d", n_tests, issued,
			hs_count, err_count);
		if (err_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
